//--- hdl/dma_macros.svh
// widths, queue depths, register offsets and almost-full level
// for the packet DMA engine

`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

`define DMA_BEAT_W        134     // tag + invalid count + payload
`define DMA_DATA_W        128
`define DMA_WORD_W        32      // SRAM and peripheral word
`define DMA_LEN_W         16      // packet length in bytes

`define DMA_PKT_DEPTH     64      // packet buffer, in beats
`define DMA_DESC_DEPTH    4       // descriptor and completion queues
`define DMA_ALF_LEVEL     20      // alf when buffer holds more beats than this

// register byte offsets
`define DMA_REG_CTRL      8'h00
`define DMA_REG_DESC      8'h04
`define DMA_REG_CPL_ADDR  8'h08
`define DMA_REG_CPL_LEN   8'h0C
`define DMA_REG_STATUS    8'h10

`endif

//--- hdl/dma_pkg.sv
// shared types of the packet DMA engine
// beat tag, beat layout, control register and peripheral write word

`include "dma_macros.svh"

package dma_pkg;

  // position of a beat inside its packet
  typedef enum logic [1:0] {
    TAG_MID    = 2'b00,
    TAG_HEAD   = 2'b01,
    TAG_TAIL   = 2'b10,
    TAG_SINGLE = 2'b11   // head and tail at once
  } beat_tag_e;

  // one ingress beat, data leaves msw first
  typedef struct packed {
    beat_tag_e                tag;
    logic [3:0]               inval;   // invalid bytes, tail only
    logic [`DMA_DATA_W-1:0]   data;
  } pkt_beat_t;

  typedef struct packed {
    logic [29:0]  rsvd;
    logic         int_en;     // irq on pending completions
    logic         start_en;   // accept packets
  } ctrl_reg_t;

  // write word, control bits for CTRL, buffer address for DESC
  typedef union packed {
    ctrl_reg_t                ctrl;
    logic [`DMA_WORD_W-1:0]   addr;
  } csr_wword_u;

endpackage

//--- hdl/dma_if.sv
// descriptor link, register decode to SRAM writer
// completion link, writer to completion queue to register decode

`timescale 1ns/1ps
`include "dma_macros.svh"

interface dma_desc_if;
  logic                     desc_valid;   // queue not empty
  logic [`DMA_WORD_W-1:0]   desc_addr;    // head buffer address
  logic                     desc_pop;     // one-cycle strobe

  modport source (output desc_valid, desc_addr, input desc_pop);
  modport sink   (input desc_valid, desc_addr, output desc_pop);
endinterface

interface dma_cpl_if;
  // writer side
  logic                     cpl_push;
  logic [`DMA_WORD_W-1:0]   cpl_addr;
  logic [`DMA_LEN_W-1:0]    cpl_len;
  // queue head, seen by decode
  logic                     cpl_valid;
  logic [`DMA_WORD_W-1:0]   cpl_head_addr;
  logic [`DMA_LEN_W-1:0]    cpl_head_len;
  logic                     cpl_pop;

  modport writer (output cpl_push, cpl_addr, cpl_len);
  modport queue  (input  cpl_push, cpl_addr, cpl_len, cpl_pop,
                  output cpl_valid, cpl_head_addr, cpl_head_len);
  modport reader (input  cpl_valid, cpl_head_addr, cpl_head_len,
                  output cpl_pop);
endinterface

//--- hdl/dma_sync_fifo.sv
// generic synchronous FIFO
// show-ahead head, empty and full flags, used-word count

`timescale 1ns/1ps

module dma_sync_fifo #(
   parameter int WIDTH = 32
  ,parameter int DEPTH = 4     // power of two
)(
   input  logic                     i_clk
  ,input  logic                     i_rst
  ,input  logic                     i_wr      // ignored when full
  ,input  logic [WIDTH-1:0]         i_din
  ,input  logic                     i_rd      // ignored when empty
  ,output logic [WIDTH-1:0]         o_dout    // head entry
  ,output logic                     o_empty
  ,output logic                     o_full
  ,output logic [$clog2(DEPTH):0]   o_used
);
  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign do_wr   = i_wr && !o_full;
  assign do_rd   = i_rd && !o_empty;
  assign o_empty = (o_used == '0);
  assign o_full  = (o_used == DEPTH);
  assign o_dout  = mem[rd_ptr];   // show-ahead

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      o_used <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap on their own
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   o_used <= o_used + 1'b1;
        2'b01:   o_used <= o_used - 1'b1;
        default: o_used <= o_used;          // none or both
      endcase
    end
  end

  // storage array
  always_ff @(posedge i_clk) begin
    if (do_wr) mem[wr_ptr] <= i_din;
  end

endmodule

//--- hdl/dma_pkt_ingress.sv
// packet ingress into the beat buffer
// start gating per packet, byte length queue, almost-full flag

`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_pkt_ingress import dma_pkg::*; (
   input  logic                   i_clk
  ,input  logic                   i_rst
  ,input  logic                   i_data_valid
  ,input  pkt_beat_t              i_data
  ,input  logic                   i_start_en
  ,input  logic                   i_beat_pop
  ,input  logic                   i_len_pop
  ,output pkt_beat_t              o_beat        // buffer head
  ,output logic                   o_pkt_empty   // buffer holds no beat
  ,output logic                   o_len_valid
  ,output logic [`DMA_LEN_W-1:0]  o_len
  ,output logic                   o_alf_dma
);
  localparam int UW = $clog2(`DMA_PKT_DEPTH) + 1;

  logic                   is_head;
  logic                   is_tail;
  logic                   take_q;       // start_en seen at last head
  logic                   keep;
  logic [`DMA_LEN_W-1:0]  byte_cnt;     // bytes so far in this packet
  logic [`DMA_LEN_W-1:0]  len_now;
  logic                   len_empty;
  logic [UW-1:0]          beat_used;

  assign is_head = (i_data.tag == TAG_HEAD) || (i_data.tag == TAG_SINGLE);
  assign is_tail = (i_data.tag == TAG_TAIL) || (i_data.tag == TAG_SINGLE);

  // head decides for the whole packet
  assign keep    = i_data_valid && (is_head ? i_start_en : take_q);

  // running length incl. this beat, tail drops its invalid bytes
  assign len_now = (is_head ? '0 : byte_cnt) + `DMA_LEN_W'(16)
                   - (is_tail ? `DMA_LEN_W'(i_data.inval) : '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      take_q   <= 1'b0;
      byte_cnt <= '0;
    end else begin
      if (i_data_valid && is_head) take_q <= i_start_en;
      if (keep) byte_cnt <= len_now;
    end
  end

  // beats land one cycle after valid, lost when full
  dma_sync_fifo #(.WIDTH(`DMA_BEAT_W), .DEPTH(`DMA_PKT_DEPTH)) beat_buf (
    .i_clk    (i_clk        ),
    .i_rst    (i_rst        ),
    .i_wr     (keep         ),
    .i_din    (i_data       ),
    .i_rd     (i_beat_pop   ),
    .o_dout   (o_beat       ),
    .o_empty  (o_pkt_empty  ),
    .o_full   (             ),
    .o_used   (beat_used    )
  );

  // length only at the tail, so a queued length means a complete packet
  dma_sync_fifo #(.WIDTH(`DMA_LEN_W), .DEPTH(`DMA_PKT_DEPTH)) len_q (
    .i_clk    (i_clk              ),
    .i_rst    (i_rst              ),
    .i_wr     (keep && is_tail    ),
    .i_din    (len_now            ),
    .i_rd     (i_len_pop          ),
    .o_dout   (o_len              ),
    .o_empty  (len_empty          ),
    .o_full   (                   ),
    .o_used   (                   )
  );

  assign o_len_valid = !len_empty;
  assign o_alf_dma   = (beat_used > `DMA_ALF_LEVEL);   // upstream warning

endmodule

//--- hdl/dma_csr_decode.sv
// peripheral register decode
// control register, descriptor queue, completion read-out, read mux

`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_csr_decode import dma_pkg::*; (
   input  logic                   i_clk
  ,input  logic                   i_rst
  ,input  logic                   i_peri_rden
  ,input  logic                   i_peri_wren
  ,input  logic [`DMA_WORD_W-1:0] i_peri_addr
  ,input  csr_wword_u             i_peri_wdata
  ,output logic [`DMA_WORD_W-1:0] o_peri_rdata
  ,output logic                   o_peri_ready
  ,output logic                   o_start_en
  ,output logic                   o_int_en
  ,dma_desc_if.source             desc
  ,dma_cpl_if.reader              cpl
  ,input  logic                   i_pkt_empty
);
  localparam int DUW = $clog2(`DMA_DESC_DEPTH) + 1;

  ctrl_reg_t              ctrl_q;
  logic [7:0]             reg_off;
  logic                   desc_wr;
  logic                   desc_empty;
  logic                   desc_full;
  logic [DUW-1:0]         desc_used;
  logic [`DMA_WORD_W-1:0] rd_mux;

  assign reg_off = i_peri_addr[7:0];   // upper bits ignored

  // full queue drops the write
  assign desc_wr     = i_peri_wren && (reg_off == `DMA_REG_DESC) && !desc_full;
  // reading CPL_ADDR consumes the entry
  assign cpl.cpl_pop = i_peri_rden && (reg_off == `DMA_REG_CPL_ADDR) && cpl.cpl_valid;

  dma_sync_fifo #(.WIDTH(`DMA_WORD_W), .DEPTH(`DMA_DESC_DEPTH)) desc_q (
    .i_clk    (i_clk              ),
    .i_rst    (i_rst              ),
    .i_wr     (desc_wr            ),
    .i_din    (i_peri_wdata.addr  ),   // address view
    .i_rd     (desc.desc_pop      ),
    .o_dout   (desc.desc_addr     ),
    .o_empty  (desc_empty         ),
    .o_full   (desc_full          ),
    .o_used   (desc_used          )
  );
  assign desc.desc_valid = !desc_empty;

  always_comb begin
    rd_mux = '0;
    case (reg_off)
      `DMA_REG_CTRL:     rd_mux = ctrl_q;
      `DMA_REG_DESC:     rd_mux = `DMA_WORD_W'(desc_used);   // pending descriptors
      `DMA_REG_CPL_ADDR: rd_mux = cpl.cpl_valid ? cpl.cpl_head_addr : '0;
      `DMA_REG_CPL_LEN:  rd_mux = cpl.cpl_valid ? `DMA_WORD_W'(cpl.cpl_head_len) : '0;
      `DMA_REG_STATUS:   rd_mux = {29'b0, i_pkt_empty, cpl.cpl_valid, desc_full};
      default:           rd_mux = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ctrl_q       <= '0;
      o_peri_ready <= 1'b0;
      o_peri_rdata <= '0;
    end else begin
      o_peri_ready <= i_peri_rden || i_peri_wren;   // one cycle later
      o_peri_rdata <= i_peri_rden ? rd_mux : '0;    // zero outside ready
      if (i_peri_wren && (reg_off == `DMA_REG_CTRL)) begin
        // control view, reserved bits kept clear
        ctrl_q.start_en <= i_peri_wdata.ctrl.start_en;
        ctrl_q.int_en   <= i_peri_wdata.ctrl.int_en;
      end
    end
  end

  assign o_start_en = ctrl_q.start_en;
  assign o_int_en   = ctrl_q.int_en;

endmodule

//--- hdl/dma_sram_writer.sv
// SRAM write engine
// pairs a packet length with a descriptor, streams 32-bit words
// under grant back-pressure, then reports completion

`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_sram_writer import dma_pkg::*; (
   input  logic                   i_clk
  ,input  logic                   i_rst
  ,input  pkt_beat_t              i_beat        // buffer head, show-ahead
  ,input  logic                   i_len_valid
  ,input  logic [`DMA_LEN_W-1:0]  i_len
  ,output logic                   o_beat_pop
  ,output logic                   o_len_pop
  ,dma_desc_if.sink               desc
  ,dma_cpl_if.writer              cpl
  ,output logic                   o_dma_wren
  ,output logic [`DMA_WORD_W-1:0] o_dma_addr
  ,output logic [`DMA_WORD_W-1:0] o_dma_wdata
  ,input  logic                   i_dma_gnt
);
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WORD,    // holding a word until grant
    ST_DONE     // completion push
  } wr_state_e;

  wr_state_e              state;
  logic                   start;
  logic                   xfer;         // word accepted this cycle
  logic                   last_word;
  logic [`DMA_LEN_W:0]    len_rnd;      // length + 3, no overflow
  logic [`DMA_LEN_W-2:0]  words_left;
  logic [1:0]             word_idx;     // word within current beat
  logic [`DMA_WORD_W-1:0] start_addr;
  logic [`DMA_LEN_W-1:0]  len_q;

  assign start     = (state == ST_IDLE) && i_len_valid && desc.desc_valid;
  assign xfer      = (state == ST_WORD) && i_dma_gnt;
  assign last_word = (words_left == 1);
  assign len_rnd   = {1'b0, i_len} + (`DMA_LEN_W+1)'(3);

  assign o_len_pop     = start;
  assign desc.desc_pop = start;
  // beat done after its fourth word or the packet's last one
  assign o_beat_pop    = xfer && ((word_idx == 2'd3) || last_word);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (start) state <= ST_WORD;
        ST_WORD: if (xfer && last_word) state <= ST_DONE;
        default: state <= ST_IDLE;   // done lasts one cycle
      endcase
    end
  end

  // transfer bookkeeping
  always_ff @(posedge i_clk) begin
    if (start) begin
      start_addr <= desc.desc_addr;
      o_dma_addr <= desc.desc_addr;
      len_q      <= i_len;
      words_left <= len_rnd[`DMA_LEN_W:2];   // ceil(len / 4)
      word_idx   <= '0;
    end else if (xfer) begin
      o_dma_addr <= o_dma_addr + `DMA_WORD_W'(4);
      words_left <= words_left - 1'b1;
      word_idx   <= word_idx + 1'b1;         // wraps at the beat boundary
    end
  end

  assign o_dma_wren  = (state == ST_WORD);
  // msw first, head beat stays put until popped
  assign o_dma_wdata = i_beat.data[`DMA_DATA_W-1 - `DMA_WORD_W*word_idx -: `DMA_WORD_W];

  // one cycle after the last granted word
  assign cpl.cpl_push = (state == ST_DONE);
  assign cpl.cpl_addr = start_addr;
  assign cpl.cpl_len  = len_q;

endmodule

//--- hdl/dma_completion.sv
// completion queue for finished transfers
// interrupt while entries wait and int_en is set

`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_completion (
   input  logic     i_clk
  ,input  logic     i_rst
  ,input  logic     i_int_en
  ,dma_cpl_if.queue cpl
  ,output logic     o_peri_int
);
  localparam int EW = `DMA_WORD_W + `DMA_LEN_W;   // {addr, len}

  logic          cpl_empty;
  logic [EW-1:0] head;

  dma_sync_fifo #(.WIDTH(EW), .DEPTH(`DMA_DESC_DEPTH)) cpl_q (
    .i_clk    (i_clk                        ),
    .i_rst    (i_rst                        ),
    .i_wr     (cpl.cpl_push                 ),
    .i_din    ({cpl.cpl_addr, cpl.cpl_len}  ),
    .i_rd     (cpl.cpl_pop                  ),
    .o_dout   (head                         ),
    .o_empty  (cpl_empty                    ),
    .o_full   (                             ),
    .o_used   (                             )
  );

  assign cpl.cpl_valid     = !cpl_empty;
  assign cpl.cpl_head_addr = head[EW-1 -: `DMA_WORD_W];
  assign cpl.cpl_head_len  = head[`DMA_LEN_W-1:0];

  // falls once software has drained the queue
  assign o_peri_int = !cpl_empty && i_int_en;

endmodule

//--- hdl/dma_engine.sv
// top level of the single-channel packet DMA engine
// ingress, register decode, SRAM writer, completion queue

`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_engine import dma_pkg::*; (
   input  logic                   i_clk
  ,input  logic                   i_rst
  // packet ingress
  ,input  logic                   i_data_valid
  ,input  logic [`DMA_BEAT_W-1:0] i_data
  ,output logic                   o_alf_dma
  // SRAM write port
  ,output logic                   o_dma_wren
  ,output logic [`DMA_WORD_W-1:0] o_dma_addr
  ,output logic [`DMA_WORD_W-1:0] o_dma_wdata
  ,input  logic                   i_dma_gnt
  // peripheral register port
  ,input  logic                   i_peri_rden
  ,input  logic                   i_peri_wren
  ,input  logic [`DMA_WORD_W-1:0] i_peri_addr
  ,input  logic [`DMA_WORD_W-1:0] i_peri_wdata
  ,output logic [`DMA_WORD_W-1:0] o_peri_rdata
  ,output logic                   o_peri_ready
  ,output logic                   o_peri_int
);
  pkt_beat_t              w_beat;         // buffer head to writer
  logic                   w_pkt_empty;
  logic                   w_beat_pop;
  logic                   w_len_valid;
  logic [`DMA_LEN_W-1:0]  w_len;
  logic                   w_len_pop;
  logic                   w_start_en;
  logic                   w_int_en;

  dma_desc_if desc_if ();
  dma_cpl_if  cpl_if ();

  dma_pkt_ingress u_ingress (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_data_valid (i_data_valid ),
    .i_data       (i_data       ),
    .i_start_en   (w_start_en   ),
    .i_beat_pop   (w_beat_pop   ),
    .i_len_pop    (w_len_pop    ),
    .o_beat       (w_beat       ),
    .o_pkt_empty  (w_pkt_empty  ),
    .o_len_valid  (w_len_valid  ),
    .o_len        (w_len        ),
    .o_alf_dma    (o_alf_dma    )
  );

  dma_csr_decode u_decode (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_peri_rden  (i_peri_rden  ),
    .i_peri_wren  (i_peri_wren  ),
    .i_peri_addr  (i_peri_addr  ),
    .i_peri_wdata (i_peri_wdata ),
    .o_peri_rdata (o_peri_rdata ),
    .o_peri_ready (o_peri_ready ),
    .o_start_en   (w_start_en   ),
    .o_int_en     (w_int_en     ),
    .desc         (desc_if      ),
    .cpl          (cpl_if       ),
    .i_pkt_empty  (w_pkt_empty  )
  );

  dma_sram_writer u_writer (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_beat       (w_beat       ),
    .i_len_valid  (w_len_valid  ),
    .i_len        (w_len        ),
    .o_beat_pop   (w_beat_pop   ),
    .o_len_pop    (w_len_pop    ),
    .desc         (desc_if      ),
    .cpl          (cpl_if       ),
    .o_dma_wren   (o_dma_wren   ),
    .o_dma_addr   (o_dma_addr   ),
    .o_dma_wdata  (o_dma_wdata  ),
    .i_dma_gnt    (i_dma_gnt    )
  );

  dma_completion u_completion (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_int_en     (w_int_en     ),
    .cpl          (cpl_if       ),
    .o_peri_int   (o_peri_int   )
  );

endmodule

//--- tb/dma_engine_assert.sv
// protocol assertions on the DMA engine ports
// peripheral ready pulse, SRAM hold under back-pressure, reset state

`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_engine_assert (
   input logic                   i_clk
  ,input logic                   i_rst
  ,input logic                   o_peri_ready
  ,input logic                   o_dma_wren
  ,input logic [`DMA_WORD_W-1:0] o_dma_addr
  ,input logic [`DMA_WORD_W-1:0] o_dma_wdata
  ,input logic                   i_dma_gnt
);
  int unsigned fail_cnt;   // failed assertions so far

  initial fail_cnt = 0;

  // ready is a single-cycle strobe
  ready_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
    o_peri_ready |=> !o_peri_ready)
    else begin
      $error("o_peri_ready high two cycles in a row");
      fail_cnt++;
    end

  // word held until grant
  hold_until_gnt: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_dma_wren && !i_dma_gnt) |=> ($stable(o_dma_addr) && $stable(o_dma_wdata)))
    else begin
      $error("SRAM address or data changed while waiting for grant");
      fail_cnt++;
    end

  // checked one edge later, state is unknown before the first reset edge
  wren_low_in_reset: assert property (@(posedge i_clk) i_rst |=> !o_dma_wren)
    else begin
      $error("o_dma_wren high during reset");
      fail_cnt++;
    end

endmodule

bind dma_engine dma_engine_assert u_assert (
  .i_clk        (i_clk        ),
  .i_rst        (i_rst        ),
  .o_peri_ready (o_peri_ready ),
  .o_dma_wren   (o_dma_wren   ),
  .o_dma_addr   (o_dma_addr   ),
  .o_dma_wdata  (o_dma_wdata  ),
  .i_dma_gnt    (i_dma_gnt    )
);

//--- tb/tb_dma_engine.sv
// directed testbench for the packet DMA engine
// register access, packet ingress, SRAM write scoreboard, watchdog

`timescale 1ns/1ps
`include "dma_macros.svh"

module tb_dma_engine import dma_pkg::*; ();
  localparam int          CLK_PERIOD  = 40;
  localparam int          NUM_TESTS   = 6;
  localparam int          TEST_BUDGET = 1500;   // cycles per test
  localparam logic [31:0] SEED        = 32'h583250b8;

  logic                   i_clk;
  logic                   i_rst;
  logic                   i_data_valid;
  logic [`DMA_BEAT_W-1:0] i_data;
  logic                   o_alf_dma;
  logic                   o_dma_wren;
  logic [31:0]            o_dma_addr;
  logic [31:0]            o_dma_wdata;
  logic                   i_dma_gnt;
  logic                   i_peri_rden;
  logic                   i_peri_wren;
  logic [31:0]            i_peri_addr;
  logic [31:0]            i_peri_wdata;
  logic [31:0]            o_peri_rdata;
  logic                   o_peri_ready;
  logic                   o_peri_int;

  logic [31:0] exp_addr[$];   // expected SRAM words
  logic [31:0] exp_data[$];
  logic [31:0] got_addr[$];   // words seen on the port
  logic [31:0] got_data[$];

  dma_engine DUT (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_data_valid (i_data_valid ),
    .i_data       (i_data       ),
    .o_alf_dma    (o_alf_dma    ),
    .o_dma_wren   (o_dma_wren   ),
    .o_dma_addr   (o_dma_addr   ),
    .o_dma_wdata  (o_dma_wdata  ),
    .i_dma_gnt    (i_dma_gnt    ),
    .i_peri_rden  (i_peri_rden  ),
    .i_peri_wren  (i_peri_wren  ),
    .i_peri_addr  (i_peri_addr  ),
    .i_peri_wdata (i_peri_wdata ),
    .o_peri_rdata (o_peri_rdata ),
    .o_peri_ready (o_peri_ready ),
    .o_peri_int   (o_peri_int   )
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD/2) i_clk = ~i_clk;

  task automatic abort_run(input string what);
    $display("ERROR t=%0t %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "stopped on first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "stopped on first error");
    end
  endtask

  // a word moves on the next rising edge when wren and gnt are both high
  task automatic collect_sram_writes();
    forever begin
      @(negedge i_clk);
      if (!i_rst && o_dma_wren && i_dma_gnt) begin
        got_addr.push_back(o_dma_addr);
        got_data.push_back(o_dma_wdata);
      end
    end
  endtask

  initial collect_sram_writes();

  // any protocol assertion failure ends the run at once
  initial begin
    wait (DUT.u_assert.fail_cnt != 0);
    abort_run("protocol assertion failed in the bound checker");
  end

  // random grant from its own seeded process
  initial begin
    i_dma_gnt = 1'b0;
    void'($urandom(SEED));
    forever begin
      @(posedge i_clk);
      #2;
      i_dma_gnt = $urandom % 2;
    end
  end

  task automatic peri_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge i_clk);
    #2;
    i_peri_wren  = wr;
    i_peri_rden  = !wr;
    i_peri_addr  = addr;
    i_peri_wdata = wdata;
    @(posedge i_clk);
    #2;
    i_peri_wren = 1'b0;
    i_peri_rden = 1'b0;
    @(negedge i_clk);   // ready due one cycle after the access
    check_eq("o_peri_ready", 1, o_peri_ready);
    rdata = o_peri_rdata;
    @(negedge i_clk);   // pulse over and data back to zero
    check_eq("o_peri_ready", 0, o_peri_ready);
    check_eq("o_peri_rdata", 0, o_peri_rdata);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    peri_access(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    peri_access(1'b0, addr, '0, data);
  endtask

  // beats back to back with words expected msw first up to ceil(len/4)
  task automatic send_packet(input int pid, input int nbeats, input int inval,
                             input logic [31:0] base, input bit expect_wr);
    logic [127:0] d;
    beat_tag_e    tag;
    int           nwords;
    int           w;
    nwords = (16 * nbeats - inval + 3) / 4;
    w = 0;
    for (int b = 0; b < nbeats; b++) begin
      for (int k = 0; k < 4; k++) begin
        d[127-32*k -: 32] = {8'(pid), 8'(b), 8'(k), 8'h5a};
        if (expect_wr && w < nwords) begin
          exp_addr.push_back(base + 4 * w);
          exp_data.push_back(d[127-32*k -: 32]);
          w++;
        end
      end
      if (nbeats == 1) tag = TAG_SINGLE;
      else if (b == 0) tag = TAG_HEAD;
      else if (b == nbeats - 1) tag = TAG_TAIL;
      else tag = TAG_MID;
      @(posedge i_clk);
      #2;
      i_data_valid = 1'b1;
      i_data       = {tag, (b == nbeats - 1) ? 4'(inval) : 4'd0, d};
    end
  endtask

  task automatic idle_ingress();
    @(posedge i_clk);
    #2;
    i_data_valid = 1'b0;
  endtask

  task automatic wait_sram_writes();
    int n;
    n = 0;
    while (got_addr.size() < exp_addr.size() && n < TEST_BUDGET) begin
      @(negedge i_clk);
      n++;
    end
    if (got_addr.size() < exp_addr.size()) abort_run("SRAM writes did not arrive");
    while (exp_addr.size() > 0) begin
      check_eq("o_dma_addr", exp_addr.pop_front(), got_addr.pop_front());
      check_eq("o_dma_wdata", exp_data.pop_front(), got_data.pop_front());
    end
    check_eq("extra SRAM writes", 0, got_addr.size());
  endtask

  // waits for a queued completion, then reads length and address
  task automatic pop_completion(input logic [31:0] addr, input logic [31:0] len);
    logic [31:0] rd;
    int          n;
    n = 0;
    read_reg(`DMA_REG_STATUS, rd);
    while (!rd[1] && n < 50) begin
      read_reg(`DMA_REG_STATUS, rd);
      n++;
    end
    if (!rd[1]) abort_run("no completion queued after transfer");
    read_reg(`DMA_REG_CPL_LEN, rd);
    check_eq("cpl_len", len, rd);
    read_reg(`DMA_REG_CPL_ADDR, rd);
    check_eq("cpl_addr", addr, rd);
  endtask

  task automatic reset_state_and_ctrl();
    logic [31:0] rd;
    @(negedge i_clk);
    check_eq("o_dma_wren", 0, o_dma_wren);
    check_eq("o_peri_ready", 0, o_peri_ready);
    check_eq("o_peri_int", 0, o_peri_int);
    check_eq("o_alf_dma", 0, o_alf_dma);
    read_reg(`DMA_REG_CTRL, rd);
    check_eq("ctrl", 0, rd);
    write_reg(`DMA_REG_CTRL, 32'h2);
    read_reg(`DMA_REG_CTRL, rd);
    check_eq("ctrl", 32'h2, rd);
    write_reg(`DMA_REG_CTRL, 32'h3);   // start and irq on from here
    read_reg(`DMA_REG_CTRL, rd);
    check_eq("ctrl", 32'h3, rd);
  endtask

  task automatic single_beat_packet();
    send_packet(1, 1, 4, 32'h0000_1000, 1'b1);   // 12 bytes, 3 words
    idle_ingress();
    write_reg(`DMA_REG_DESC, 32'h0000_1000);
    wait_sram_writes();
    pop_completion(32'h0000_1000, 12);
  endtask

  task automatic completion_irq();
    logic [31:0] rd;
    int          n;
    n = 0;
    send_packet(2, 2, 5, 32'h0000_2004, 1'b1);   // 27 bytes, 7 words
    idle_ingress();
    write_reg(`DMA_REG_DESC, 32'h0000_2004);
    wait_sram_writes();
    while (!o_peri_int && n < 20) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_peri_int) abort_run("o_peri_int did not rise after a completion");
    pop_completion(32'h0000_2004, 27);
    check_eq("o_peri_int", 0, o_peri_int);   // queue drained
    read_reg(`DMA_REG_CPL_LEN, rd);          // empty queue reads zero
    check_eq("cpl_len empty", 0, rd);
  endtask

  task automatic two_packets_in_order();
    write_reg(`DMA_REG_DESC, 32'h0000_3000);
    write_reg(`DMA_REG_DESC, 32'h0000_4000);
    send_packet(3, 3, 0, 32'h0000_3000, 1'b1);   // 48 bytes
    send_packet(4, 2, 7, 32'h0000_4000, 1'b1);   // 25 bytes, 7 words
    idle_ingress();
    wait_sram_writes();
    pop_completion(32'h0000_3000, 48);
    pop_completion(32'h0000_4000, 25);
  endtask

  task automatic start_gating();
    logic [31:0] rd;
    write_reg(`DMA_REG_CTRL, 32'h2);   // start_en clear
    send_packet(5, 2, 3, 32'h0, 1'b0);   // dropped whole
    idle_ingress();
    write_reg(`DMA_REG_DESC, 32'h0000_5000);
    repeat (40) @(negedge i_clk);   // no SRAM write may appear meanwhile
    check_eq("SRAM writes while stopped", 0, got_addr.size());
    read_reg(`DMA_REG_STATUS, rd);
    check_eq("status buffer empty", 1, rd[2]);
    // leftover descriptor goes to the next accepted packet
    write_reg(`DMA_REG_CTRL, 32'h3);
    send_packet(6, 1, 0, 32'h0000_5000, 1'b1);
    idle_ingress();
    wait_sram_writes();
    pop_completion(32'h0000_5000, 16);
  endtask

  task automatic almost_full_drain();
    logic [31:0] rd;
    send_packet(7, 11, 0, 32'h0000_6000, 1'b1);   // 176 bytes
    send_packet(8, 11, 9, 32'h0000_7000, 1'b1);   // 167 bytes, 42 words
    idle_ingress();
    @(negedge i_clk);
    check_eq("o_alf_dma", 1, o_alf_dma);   // 22 beats held
    read_reg(`DMA_REG_STATUS, rd);
    check_eq("status buffer empty", 0, rd[2]);
    write_reg(`DMA_REG_DESC, 32'h0000_6000);
    write_reg(`DMA_REG_DESC, 32'h0000_7000);
    wait_sram_writes();
    check_eq("o_alf_dma", 0, o_alf_dma);
    pop_completion(32'h0000_6000, 176);
    pop_completion(32'h0000_7000, 167);
    read_reg(`DMA_REG_STATUS, rd);
    check_eq("status buffer empty", 1, rd[2]);
  endtask

  initial begin
    #(NUM_TESTS * TEST_BUDGET * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", NUM_TESTS * TEST_BUDGET);
    $display("=== FAIL ===");
    $fatal(1, "run did not finish in time");
  end

  initial begin
    i_rst        = 1'b1;
    i_data_valid = 1'b0;
    i_data       = '0;
    i_peri_rden  = 1'b0;
    i_peri_wren  = 1'b0;
    i_peri_addr  = '0;
    i_peri_wdata = '0;
    repeat (5) @(posedge i_clk);
    #2;
    i_rst = 1'b0;
    reset_state_and_ctrl();
    single_beat_packet();
    completion_irq();
    two_packets_in_order();
    start_gating();
    almost_full_drain();
    repeat (4) @(negedge i_clk);
    if (DUT.u_assert.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("%0d assertion failures", DUT.u_assert.fail_cnt);
      $display("=== FAIL ===");
      $fatal(1, "assertions failed");
    end
  end

endmodule

//--- files.f
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_if.sv
hdl/dma_sync_fifo.sv
hdl/dma_pkt_ingress.sv
hdl/dma_csr_decode.sv
hdl/dma_sram_writer.sv
hdl/dma_completion.sv
hdl/dma_engine.sv
tb/dma_engine_assert.sv
tb/tb_dma_engine.sv
